// File: src.f
src/apb_sub_pkg.sv
src/ahb_apb_bridge.sv
src/apb_slot_decoder.sv
src/alut_regs.sv
src/apb_subsystem.sv
verif/mac_apb_model.sv
verif/tb_apb_subsystem.sv

// File: Bender.yml
package:
  name: apb_subsystem

sources:
  # RTL in compile order
  - src/apb_sub_pkg.sv
  - src/ahb_apb_bridge.sv
  - src/apb_slot_decoder.sv
  - src/alut_regs.sv
  - src/apb_subsystem.sv

  # Verification sources
  - target: test
    files:
      - verif/mac_apb_model.sv
      - verif/tb_apb_subsystem.sv

// File: verif/tb_apb_subsystem.sv
// Self-checking testbench that runs the APB subsystem as simulation top against four MAC slot models
`timescale 1ns/1ps

module tb_apb_subsystem;

   localparam logic [31:0] base_addr   = 32'h00A0_0000;
   localparam logic [31:0] mac_lo_addr = base_addr + 32'(apb_sub_pkg::alut_mac_lo_offs);
   localparam logic [31:0] mac_hi_addr = base_addr + 32'(apb_sub_pkg::alut_mac_hi_offs);
   localparam logic [31:0] cmd_addr    = base_addr + 32'(apb_sub_pkg::alut_cmd_offs);
   localparam logic [31:0] result_addr = base_addr + 32'(apb_sub_pkg::alut_result_offs);
   // Up to 95 transfers of at most 9 cycles and a twofold margin
   localparam int          max_cycles  = 2000;

   logic                                              hclk;
   logic                                              rst_n;
   apb_sub_pkg::ahb_req_t                             ahb_req;
   logic [31:0]                                       hwdata;
   logic [31:0]                                       hrdata;
   logic                                              hready;
   logic [1:0]                                        hresp;
   apb_sub_pkg::apb_req_t                             apb_req;
   logic [apb_sub_pkg::num_macs-1:0]                  psel_mac;
   apb_sub_pkg::apb_rsp_t [apb_sub_pkg::num_macs-1:0] mac_rsp;

   // Expected outcome of the transfer in flight
   logic        in_flight = 1'b0;
   int          exp_slot  = -1;
   logic [1:0]  exp_resp  = apb_sub_pkg::hresp_okay;
   logic        exp_chk_rd = 1'b0;
   logic [31:0] exp_rdata = '0;
   logic [31:0] rand_q    = 32'd22;
   int          cycle_cnt = 0;
   // Last written word per MAC slot and word
   logic [31:0] mac_mem [1:apb_sub_pkg::num_macs][16];

   initial hclk = 1'b0;
   always #4 hclk = ~hclk;

   apb_subsystem #(
      .base_addr  (base_addr),
      .slot_bits  (16),
      .alut_depth (8)
   ) i_apb_subsystem (
      .hclk     (hclk),
      .rst_n    (rst_n),
      .ahb_req  (ahb_req),
      .hwdata   (hwdata),
      .hrdata   (hrdata),
      .hready   (hready),
      .hresp    (hresp),
      .apb_req  (apb_req),
      .psel_mac (psel_mac),
      .mac_rsp  (mac_rsp)
   );

   for (genvar g = 0; g < apb_sub_pkg::num_macs; g++) begin : g_mac
      mac_apb_model #(
         .fill_base (base_addr + 32'((g + 1) << 16))
      ) i_mac_apb_model (
         .hclk    (hclk),
         .rst_n   (rst_n),
         .psel    (psel_mac[g]),
         .apb_req (apb_req),
         .apb_rsp (mac_rsp[g])
      );
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] x);
      return x * 32'd1103515245 + 32'd12345;
   endfunction

   // Slot index of an address or -1 when unmapped
   function automatic int slot_of(input logic [31:0] addr);
      if ((addr[31:20] == base_addr[31:20]) && (addr[19:16] < 4'd5)) begin
         return int'(addr[19:16]);
      end
      return -1;
   endfunction

   task automatic report_err(input string msg);
      $display("ERR %0t: %s", $time, msg);
      $display("tests failed");
      $fatal(1, "stopped at first error");
   endtask

   // ----------------------------------------------------------------------
   // AHB driver
   // ----------------------------------------------------------------------
   task automatic ahb_xfer(input logic [31:0] addr, input logic write,
                           input logic [31:0] wdata, input logic [31:0] rdata_exp);
      @(posedge hclk);
      ahb_req <= '{hsel: 1'b1, haddr: addr, htrans: apb_sub_pkg::htrans_nonseq,
                   hwrite: write, hready_in: 1'b1};
      // Data phase
      @(posedge hclk);
      ahb_req.htrans <= apb_sub_pkg::htrans_idle;
      hwdata         <= write ? wdata : 32'h0;
      exp_slot   = slot_of(addr);
      exp_resp   = (exp_slot < 0) ? apb_sub_pkg::hresp_error : apb_sub_pkg::hresp_okay;
      exp_chk_rd = !write && (exp_slot >= 0);
      exp_rdata  = rdata_exp;
      in_flight  = 1'b1;
      @(posedge hclk);
      while (!hready) begin
         @(posedge hclk);
      end
      in_flight = 1'b0;
   endtask

   task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
      ahb_xfer(addr, 1'b1, data, 32'h0);
      if (slot_of(addr) >= 1) begin
         mac_mem[slot_of(addr)][addr[5:2]] = data;
      end
   endtask

   task automatic ahb_read(input logic [31:0] addr, input logic [31:0] exp);
      ahb_xfer(addr, 1'b0, 32'h0, exp);
   endtask

   task automatic stage_mac(input logic [47:0] mac, input logic [1:0] port);
      ahb_write(mac_lo_addr, mac[31:0]);
      ahb_write(mac_hi_addr, {14'h0, port, mac[47:32]});
   endtask

   task automatic lookup_check(input logic [47:0] mac, input logic [31:0] exp);
      stage_mac(mac, 2'd0);
      ahb_write(cmd_addr, 32'h0000_0100);
      ahb_read(result_addr, exp);
   endtask

   // Hit flag in bit 31, port in 17:16, index in 2:0
   function automatic logic [31:0] hit_word(input logic [1:0] port, input logic [2:0] idx);
      return 32'h8000_0000 | (32'(port) << 16) | 32'(idx);
   endfunction

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------
   resp_a: assert property (@(posedge hclk) disable iff (!rst_n)
      $rose(hready) |-> (hresp == exp_resp) && (!exp_chk_rd || (hrdata == exp_rdata)))
      else report_err($sformatf("hresp %0d hrdata %08h, expected %0d %08h",
                                $sampled(hresp), $sampled(hrdata),
                                $sampled(exp_resp), $sampled(exp_rdata)));

   // ERROR also in the cycle before hready rises
   err_seq_a: assert property (@(posedge hclk) disable iff (!rst_n)
      $rose(hready) && (exp_resp == apb_sub_pkg::hresp_error) |->
         $past(hresp) == apb_sub_pkg::hresp_error)
      else report_err("first ERROR cycle missing");

   psel_a: assert property (@(posedge hclk) disable iff (!rst_n)
      (psel_mac != '0) |-> in_flight && (exp_slot >= 1) &&
         (psel_mac == 4'(1 << (exp_slot - 1))))
      else report_err($sformatf("psel_mac %b with slot %0d", $sampled(psel_mac),
                                $sampled(exp_slot)));

   always @(posedge hclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("Timeout, the test did not finish within %0d cycles", max_cycles);
         $display("tests failed");
         $fatal(1, "run timed out");
      end
   end

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------
   initial begin
      int          slot;
      int          word;
      logic [31:0] addr;
      rst_n   = 1'b0;
      ahb_req = '0;
      hwdata  = '0;
      for (int s = 1; s <= apb_sub_pkg::num_macs; s++) begin
         for (int w = 0; w < 16; w++) begin
            mac_mem[s][w] = base_addr + 32'(s << 16) + 32'(4 * w);
         end
      end
      repeat (10) @(posedge hclk);
      rst_n <= 1'b1;
      @(posedge hclk);
      reset_a: assert (hready && (hresp == apb_sub_pkg::hresp_okay) &&
                       (psel_mac == '0) && !apb_req.penable)
         else report_err("outputs not idle after reset");
      repeat (10) @(posedge hclk);
      ahb_read(result_addr, 32'h0);

      // Staging registers with MAC_HI keeping bits 17:0
      ahb_write(mac_lo_addr, 32'h1234_5678);
      ahb_read(mac_lo_addr, 32'h1234_5678);
      ahb_write(mac_hi_addr, 32'hFFFF_ABCD);
      ahb_read(mac_hi_addr, 32'h0003_ABCD);
      ahb_read(cmd_addr, 32'h0);

      // Second MAC stored twice so the lowest index must win
      stage_mac(48'h0011_2233_4455, 2'd1);
      ahb_write(cmd_addr, 32'd5);
      stage_mac(48'h00AA_BBCC_DDEE, 2'd2);
      ahb_write(cmd_addr, 32'd6);
      ahb_write(cmd_addr, 32'd2);
      stage_mac(48'h0200_0000_0001, 2'd3);
      ahb_write(cmd_addr, 32'd0);
      lookup_check(48'h0011_2233_4455, hit_word(2'd1, 3'd5));
      lookup_check(48'h00AA_BBCC_DDEE, hit_word(2'd2, 3'd2));
      lookup_check(48'h0200_0000_0001, hit_word(2'd3, 3'd0));
      lookup_check(48'h0BAD_0BAD_0BAD, 32'h0);

      // Random MAC traffic with every write read back at once
      for (int n = 0; n < 24; n++) begin
         rand_q = lcg_next(rand_q);
         slot   = 1 + int'(rand_q[17:16]);
         word   = int'(rand_q[21:18]);
         addr   = base_addr + 32'(slot << 16) + 32'(4 * word);
         if (rand_q[24]) begin
            rand_q = lcg_next(rand_q);
            ahb_write(addr, rand_q);
            ahb_read(addr, mac_mem[slot][word]);
         end else begin
            ahb_read(addr, mac_mem[slot][word]);
         end
      end

      // Unmapped slots and addresses outside the window
      for (int s = 5; s < 16; s++) begin
         ahb_xfer(base_addr + 32'(s << 16) + 32'h4, 1'(s), 32'hDEAD_0000, 32'h0);
      end
      ahb_xfer(32'h00B0_0000, 1'b1, 32'hDEAD_0001, 32'h0);
      ahb_xfer(32'h0000_1000, 1'b0, 32'h0, 32'h0);
      ahb_read(base_addr + 32'h0001_0000, mac_mem[1][0]);

      $display("all tests passed");
      $finish;
   end

endmodule

// File: verif/mac_apb_model.sv
// Behavioral APB slave of one MAC slot for the testbench, 16-word memory with random wait states
`timescale 1ns/1ps

module mac_apb_model #(
   parameter logic [31:0] fill_base = 32'h0000_0000,
   parameter logic [31:0] seed      = 32'd22
) (
   input  logic                  hclk,
   input  logic                  rst_n,
   input  logic                  psel,
   input  apb_sub_pkg::apb_req_t apb_req,
   output apb_sub_pkg::apb_rsp_t apb_rsp
);

   logic [31:0] mem [16];
   logic [31:0] rand_q;
   logic [1:0]  wait_q;

   function automatic logic [31:0] lcg_next(input logic [31:0] x);
      return x * 32'd1103515245 + 32'd12345;
   endfunction

   // Ready once the drawn wait states are used up
   assign apb_rsp.pready = (wait_q == 2'd0);
   assign apb_rsp.prdata = mem[apb_req.paddr[5:2]];

   always_ff @(posedge hclk or negedge rst_n) begin
      if (!rst_n) begin
         rand_q <= seed;
         wait_q <= '0;
         // Fill with the word's own byte address
         for (int i = 0; i < 16; i++) begin
            mem[i] <= fill_base + 32'(4 * i);
         end
      end else if (psel && !apb_req.penable) begin
         // Setup cycle draws 0 to 3 wait states
         wait_q <= rand_q[17:16];
         rand_q <= lcg_next(rand_q);
      end else if (psel && (wait_q != 2'd0)) begin
         wait_q <= wait_q - 2'd1;
      end else if (psel && apb_req.pwrite) begin
         mem[apb_req.paddr[5:2]] <= apb_req.pwdata;
      end
   end

endmodule

// File: src/apb_subsystem.sv
// Top level of the APB subsystem, AHB-lite port in, ALUT in slot 0 and four MAC slot ports out
`timescale 1ns/1ps

module apb_subsystem #(
   parameter logic [31:0] base_addr  = 32'h00A0_0000,
   parameter int unsigned slot_bits  = 16,
   parameter int unsigned alut_depth = 8
) (
   input  logic                                               hclk,
   input  logic                                               rst_n,
   input  apb_sub_pkg::ahb_req_t                              ahb_req,
   input  logic [31:0]                                        hwdata,
   output logic [31:0]                                        hrdata,
   output logic                                               hready,
   output logic [1:0]                                         hresp,
   output apb_sub_pkg::apb_req_t                              apb_req,
   output logic [apb_sub_pkg::num_macs-1:0]                   psel_mac,
   input  apb_sub_pkg::apb_rsp_t [apb_sub_pkg::num_macs-1:0]  mac_rsp
);

   logic                                               sel_active;
   logic                                               slot_hit;
   logic [apb_sub_pkg::num_slots-1:0]                  psel;
   apb_sub_pkg::apb_rsp_t                              slot_rsp;
   apb_sub_pkg::apb_rsp_t                              alut_rsp;
   apb_sub_pkg::apb_rsp_t [apb_sub_pkg::num_slots-1:0] slot_rsp_all;

   // ALUT in slot 0, MACs above it
   assign slot_rsp_all = {mac_rsp, alut_rsp};
   assign psel_mac     = psel[apb_sub_pkg::num_slots-1:1];

   ahb_apb_bridge i_ahb_apb_bridge (
      .hclk       (hclk),
      .rst_n      (rst_n),
      .ahb_req    (ahb_req),
      .hwdata     (hwdata),
      .hrdata     (hrdata),
      .hready     (hready),
      .hresp      (hresp),
      .apb_req    (apb_req),
      .sel_active (sel_active),
      .slot_rsp   (slot_rsp),
      .slot_hit   (slot_hit)
   );

   apb_slot_decoder #(
      .base_addr (base_addr),
      .slot_bits (slot_bits)
   ) i_apb_slot_decoder (
      .paddr       (apb_req.paddr),
      .sel_active  (sel_active),
      .slot_rsp_in (slot_rsp_all),
      .psel        (psel),
      .slot_rsp    (slot_rsp),
      .slot_hit    (slot_hit)
   );

   alut_regs #(
      .alut_depth (alut_depth)
   ) i_alut_regs (
      .hclk    (hclk),
      .rst_n   (rst_n),
      .psel    (psel[0]),
      .apb_req (apb_req),
      .apb_rsp (alut_rsp)
   );

endmodule

// File: src/alut_regs.sv
// APB register block of the MAC address lookup table, staging registers plus store/lookup command
`timescale 1ns/1ps

module alut_regs #(
   parameter int unsigned alut_depth = 8
) (
   input  logic                   hclk,
   input  logic                   rst_n,
   input  logic                   psel,
   input  apb_sub_pkg::apb_req_t  apb_req,
   output apb_sub_pkg::apb_rsp_t  apb_rsp
);

   logic [6:0]                apb_offs;
   logic                      wr_en;
   logic                      cmd_wr;
   logic                      store_wr;
   logic                      lookup_wr;
   logic [31:0]               mac_lo_q;
   logic [17:0]               mac_hi_q;
   logic [31:0]               result_q;
   logic [47:0]               staged_mac;
   logic                      lk_hit;
   logic [1:0]                lk_port;
   logic [2:0]                lk_idx;
   apb_sub_pkg::alut_entry_t  tbl_q [alut_depth];

   // ----------------------------------------------------------------------
   // Decode
   // ----------------------------------------------------------------------
   assign apb_offs   = apb_req.paddr[6:0];
   // Writes land at the end of the single access cycle
   assign wr_en      = psel && apb_req.penable && apb_req.pwrite;
   assign cmd_wr     = wr_en && (apb_offs == apb_sub_pkg::alut_cmd_offs);
   assign store_wr   = cmd_wr && !apb_req.pwdata[8];
   assign lookup_wr  = cmd_wr && apb_req.pwdata[8];
   assign staged_mac = {mac_hi_q[15:0], mac_lo_q};

   // Search from the top so the lowest match wins
   always_comb begin
      lk_hit  = 1'b0;
      lk_port = '0;
      lk_idx  = '0;
      for (int i = int'(alut_depth) - 1; i >= 0; i--) begin
         if (tbl_q[i].valid && (tbl_q[i].mac == staged_mac)) begin
            lk_hit  = 1'b1;
            lk_port = tbl_q[i].port;
            lk_idx  = 3'(i);
         end
      end
   end

   // ----------------------------------------------------------------------
   // Registers and table
   // ----------------------------------------------------------------------
   always_ff @(posedge hclk or negedge rst_n) begin
      if (!rst_n) begin
         mac_lo_q <= '0;
         mac_hi_q <= '0;
         result_q <= '0;
         for (int i = 0; i < int'(alut_depth); i++) begin
            tbl_q[i] <= '0;
         end
      end else begin
         if (wr_en && (apb_offs == apb_sub_pkg::alut_mac_lo_offs)) begin
            mac_lo_q <= apb_req.pwdata;
         end
         // Upper MAC bits plus port
         if (wr_en && (apb_offs == apb_sub_pkg::alut_mac_hi_offs)) begin
            mac_hi_q <= apb_req.pwdata[17:0];
         end
         if (store_wr && (apb_req.pwdata[2:0] < alut_depth)) begin
            tbl_q[apb_req.pwdata[2:0]] <= '{valid: 1'b1,
                                            mac:   staged_mac,
                                            port:  mac_hi_q[17:16]};
         end
         // Hit flag, port, index; a miss clears
         if (lookup_wr) begin
            result_q <= lk_hit ? {1'b1, 13'b0, lk_port, 13'b0, lk_idx} : '0;
         end
      end
   end

   // Read mux, CMD and holes read zero
   always_comb begin
      apb_rsp.pready = 1'b1;
      case (apb_offs)
         apb_sub_pkg::alut_mac_lo_offs: apb_rsp.prdata = mac_lo_q;
         apb_sub_pkg::alut_mac_hi_offs: apb_rsp.prdata = {14'b0, mac_hi_q};
         apb_sub_pkg::alut_result_offs: apb_rsp.prdata = result_q;
         default:                       apb_rsp.prdata = '0;
      endcase
   end

   // Software must keep store indices inside the table
   store_idx_a: assert property (@(posedge hclk) disable iff (!rst_n)
      store_wr |-> (apb_req.pwdata[2:0] < alut_depth))
      else $error("ALUT store to index beyond table depth");

endmodule

// File: src/apb_slot_decoder.sv
// Combinational APB slot decoder giving one-hot selects from the held address and merging responses
`timescale 1ns/1ps

module apb_slot_decoder #(
   parameter logic [31:0] base_addr = 32'h00A0_0000,
   parameter int unsigned slot_bits = 16
) (
   input  logic [31:0]                                         paddr,
   input  logic                                                sel_active,
   input  apb_sub_pkg::apb_rsp_t [apb_sub_pkg::num_slots-1:0]  slot_rsp_in,
   output logic [apb_sub_pkg::num_slots-1:0]                   psel,
   output apb_sub_pkg::apb_rsp_t                               slot_rsp,
   output logic                                                slot_hit
);

   // Window of 16 slots with only the first num_slots populated
   localparam int unsigned idx_bits = 4;
   localparam int unsigned win_lsb  = slot_bits + idx_bits;

   logic                in_window;
   logic [idx_bits-1:0] slot_idx;

   assign in_window = (paddr[31:win_lsb] == base_addr[31:win_lsb]);
   assign slot_idx  = paddr[slot_bits +: idx_bits];
   // Single point of map check
   assign slot_hit  = in_window && (slot_idx < apb_sub_pkg::num_slots);

   always_comb begin
      // Nothing selected gives a ready zero response
      psel            = '0;
      slot_rsp.prdata = '0;
      slot_rsp.pready = 1'b1;
      for (int i = 0; i < apb_sub_pkg::num_slots; i++) begin
         if (sel_active && slot_hit && (slot_idx == i)) begin
            psel[i]  = 1'b1;
            slot_rsp = slot_rsp_in[i];
         end
      end
   end

endmodule

// File: src/ahb_apb_bridge.sv
// AHB-lite slave that runs each accepted transfer as one APB setup/access sequence or an ERROR
`timescale 1ns/1ps

module ahb_apb_bridge (
   input  logic                   hclk,
   input  logic                   rst_n,
   input  apb_sub_pkg::ahb_req_t  ahb_req,
   input  logic [31:0]            hwdata,
   output logic [31:0]            hrdata,
   output logic                   hready,
   output logic [1:0]             hresp,
   output apb_sub_pkg::apb_req_t  apb_req,
   output logic                   sel_active,
   input  apb_sub_pkg::apb_rsp_t  slot_rsp,
   input  logic                   slot_hit
);

   typedef enum logic [2:0] {
      st_idle,
      st_capture,
      st_setup,
      st_access,
      st_err1,
      st_err2
   } state_t;

   state_t      state_q;
   state_t      state_d;
   logic [31:0] addr_q;
   logic        write_q;
   logic [31:0] wdata_q;
   logic [31:0] rdata_q;
   logic        accept;

   // ----------------------------------------------------------------------
   // AHB side
   // ----------------------------------------------------------------------

   // Data phase ends in idle or second error cycle
   assign hready = (state_q == st_idle) || (state_q == st_err2);
   assign hresp  = ((state_q == st_err1) || (state_q == st_err2)) ?
                   apb_sub_pkg::hresp_error : apb_sub_pkg::hresp_okay;
   assign hrdata = rdata_q;

   // Only NONSEQ and SEQ start a transfer
   assign accept = hready && ahb_req.hsel && ahb_req.hready_in &&
                   ((ahb_req.htrans == apb_sub_pkg::htrans_nonseq) ||
                    (ahb_req.htrans == apb_sub_pkg::htrans_seq));

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle, st_err2: state_d = accept ? st_capture : st_idle;
         // Map check on the held address
         st_capture:       state_d = slot_hit ? st_setup : st_err1;
         st_setup:         state_d = st_access;
         // Wait states from the slot
         st_access:        state_d = slot_rsp.pready ? st_idle : st_access;
         st_err1:          state_d = st_err2;
         default:          state_d = st_idle;
      endcase
   end

   always_ff @(posedge hclk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= st_idle;
         addr_q  <= '0;
         write_q <= 1'b0;
      end else begin
         state_q <= state_d;
         // Address and direction from the address phase
         if (accept) begin
            addr_q  <= ahb_req.haddr;
            write_q <= ahb_req.hwrite;
         end
      end
   end

   // Write data arrives one cycle after the address
   always_ff @(posedge hclk) begin
      if (state_q == st_capture) begin
         wdata_q <= hwdata;
      end
      // Read data held for the final data phase cycle
      if ((state_q == st_access) && slot_rsp.pready) begin
         rdata_q <= slot_rsp.prdata;
      end
   end

   // ----------------------------------------------------------------------
   // APB side
   // ----------------------------------------------------------------------
   assign sel_active = (state_q == st_setup) || (state_q == st_access);

   always_comb begin
      apb_req.paddr   = addr_q;
      apb_req.pwrite  = write_q;
      apb_req.penable = (state_q == st_access);
      apb_req.pwdata  = wdata_q;
   end

   // Decoder hit must hold for the whole sequence on the held address
   seq_hit_a: assert property (@(posedge hclk) disable iff (!rst_n)
      sel_active |-> slot_hit)
      else $error("APB sequence running for an unmapped address");

   // Request held from setup until the completing access cycle
   req_stable_a: assert property (@(posedge hclk) disable iff (!rst_n)
      sel_active && !(apb_req.penable && slot_rsp.pready) |=>
         $stable(apb_req.paddr) && $stable(apb_req.pwrite) && $stable(apb_req.pwdata))
      else $error("APB request changed inside a transfer");

endmodule

// File: src/apb_sub_pkg.sv
// Shared bus structs, AHB/APB codes and ALUT register map, referenced by scoped name
package apb_sub_pkg;

   // ----------------------------------------------------------------------
   // Bus structs
   // ----------------------------------------------------------------------

   // AHB address phase of one transfer, write data travels on its own
   typedef struct packed {
      logic        hsel;
      logic [31:0] haddr;
      logic [1:0]  htrans;
      logic        hwrite;
      logic        hready_in;
   } ahb_req_t;

   // Shared APB request, common to all slots
   typedef struct packed {
      logic [31:0] paddr;
      logic        pwrite;
      logic        penable;
      logic [31:0] pwdata;
   } apb_req_t;

   // Response of one slot
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
   } apb_rsp_t;

   // AHB transfer and response codes
   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_busy   = 2'b01;
   localparam logic [1:0] htrans_nonseq = 2'b10;
   localparam logic [1:0] htrans_seq    = 2'b11;
   localparam logic [1:0] hresp_okay    = 2'b00;
   localparam logic [1:0] hresp_error   = 2'b01;

   // Slot 0 is the ALUT, slots 1 to 4 the MACs
   localparam int num_slots = 5;
   localparam int num_macs  = 4;

   // ----------------------------------------------------------------------
   // ALUT map
   // ----------------------------------------------------------------------
   localparam logic [6:0] alut_mac_lo_offs = 7'h00;
   localparam logic [6:0] alut_mac_hi_offs = 7'h04;
   localparam logic [6:0] alut_cmd_offs    = 7'h08;
   localparam logic [6:0] alut_result_offs = 7'h0C;

   // One table entry
   typedef struct packed {
      logic        valid;
      logic [47:0] mac;
      logic [1:0]  port;
   } alut_entry_t;

endpackage
